// ==== rtl/game_screen.sv ====
module game_screen import screen_pkg::*; #(
    parameter int BOARD_X0 = 203,   // board top left corner
    parameter int BOARD_Y0 = 11
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [PIX_W-1:0]      x_i,
    input  logic [PIX_W-1:0]      y_i,
    // AXI4-Lite slave
    input  logic [AXI_ADDR_W-1:0] s_awaddr_i,
    input  logic                  s_awvalid_i,
    output logic                  s_awready_o,
    input  logic [AXI_DATA_W-1:0] s_wdata_i,
    input  logic [AXI_STRB_W-1:0] s_wstrb_i,
    input  logic                  s_wvalid_i,
    output logic                  s_wready_o,
    output logic [1:0]            s_bresp_o,
    output logic                  s_bvalid_o,
    input  logic                  s_bready_i,
    input  logic [AXI_ADDR_W-1:0] s_araddr_i,
    input  logic                  s_arvalid_i,
    output logic                  s_arready_o,
    output logic [AXI_DATA_W-1:0] s_rdata_o,
    output logic [1:0]            s_rresp_o,
    output logic                  s_rvalid_o,
    input  logic                  s_rready_i,
    output logic [COLOUR_W-1:0]   colour_o   // two cycles behind x_i y_i
);

    logic [SCORE_W-1:0] score;
    logic               score_load;

    piece_state_if pst ();
    pix_loc_if     loc ();

    ////////////////////////////////////////////////////////////
    // control side
    screen_regs u_regs (
        .clk_i, .rst_n_i,
        .s_awaddr_i, .s_awvalid_i, .s_awready_o,
        .s_wdata_i, .s_wstrb_i, .s_wvalid_i, .s_wready_o,
        .s_bresp_o, .s_bvalid_o, .s_bready_i,
        .s_araddr_i, .s_arvalid_i, .s_arready_o,
        .s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
        .score_o      (score),
        .score_load_o (score_load),
        .pst          (pst.regs)
    );

    score_bcd u_bcd (
        .clk_i, .rst_n_i,
        .score_i (score),
        .load_i  (score_load),
        .pst     (pst.bcd)
    );

    ////////////////////////////////////////////////////////////
    // pixel pipeline
    screen_locate #(.BOARD_X0(BOARD_X0), .BOARD_Y0(BOARD_Y0)) u_locate (
        .clk_i, .rst_n_i, .x_i, .y_i,
        .loc (loc.locate)
    );

    screen_shade u_shade (
        .clk_i, .rst_n_i,
        .loc (loc.shade),
        .pst (pst.shade),
        .colour_o
    );

endmodule

// ==== rtl/score_bcd.sv ====
module score_bcd import screen_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic [SCORE_W-1:0] score_i,
    input  logic               load_i,
    piece_state_if.bcd         pst
);

    localparam int CNT_W    = $clog2(SCORE_W + 2);
    localparam int COMMIT   = SCORE_W + 1;   // cnt of the commit cycle
    localparam int BUSY_CYC = SCORE_W + 2;   // load + shifts + commit

    logic                         busy_q;
    logic [CNT_W-1:0]             cnt_q;
    logic [SCORE_W-1:0]           bin_q;
    logic [DIGITS-1:0][BCD_W-1:0] bcd_q;      // partial result
    logic [DIGITS-1:0][BCD_W-1:0] bcd_adj;
    logic [DIGITS-1:0][BCD_W-1:0] digits_q;   // last finished result

    // add 3 to every digit above 4 ahead of the shift
    always_comb begin
        for (int i = 0; i < DIGITS; i++)
            bcd_adj[i] = (bcd_q[i] > 4'd4) ? bcd_q[i] + 4'd3 : bcd_q[i];
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q   <= 1'b0;
            cnt_q    <= '0;
            digits_q <= '0;
        end else if (load_i) begin
            busy_q <= 1'b1;   // also restarts a running conversion
            cnt_q  <= '0;
        end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_W'(COMMIT)) begin
                busy_q   <= 1'b0;
                digits_q <= bcd_q;   // display swaps in one step
            end
        end
    end

    // cnt 0 loads, 1..14 shift msb first
    always_ff @(posedge clk_i) begin
        if (busy_q && !load_i) begin
            if (cnt_q == '0) begin
                bin_q <= score_i;
                bcd_q <= '0;
            end else if (cnt_q <= CNT_W'(SCORE_W)) begin
                {bcd_q, bin_q} <= {bcd_adj, bin_q} << 1;
            end
        end
    end

    assign pst.digits = digits_q;

    // an uninterrupted conversion occupies exactly 16 cycles
    a_busy_len: assert property (@(posedge clk_i) disable iff (!rst_n_i || load_i)
        $rose(busy_q) |-> busy_q [*BUSY_CYC] ##1 !busy_q)
        else $error("bcd conversion length off");

endmodule

// ==== rtl/screen_if.sv ====
// falling piece and score digits, consumed by the shade stage
interface piece_state_if import screen_pkg::*; ();

    logic [PIECE_CELLS-1:0][CELL_X_W-1:0] piece_x;      // cell 0 in low bits
    logic [PIECE_CELLS-1:0][CELL_Y_W-1:0] piece_y;
    logic [BTYPE_W-1:0]                   block_type;
    logic [DIGITS-1:0][BCD_W-1:0]         digits;       // digit 0 is units

    modport regs  (output piece_x, piece_y, block_type);
    modport bcd   (output digits);
    modport shade (input piece_x, piece_y, block_type, digits);

endinterface

// pixel classification between pipeline stage 1 and 2
interface pix_loc_if import screen_pkg::*; ();

    logic                board_hit;    // inside board, edge lines included
    logic                on_grid;      // on a cell boundary line
    logic [CELL_X_W-1:0] cell_x;
    logic [CELL_Y_W-1:0] cell_y;
    logic                digit_hit;
    logic [DSEL_W-1:0]   digit_sel;    // bcd index, 0 is units
    logic [SEG_N-1:0]    seg_sel;      // one hot, zero in glyph holes

    modport locate (
        output board_hit, on_grid, cell_x, cell_y,
        output digit_hit, digit_sel, seg_sel
    );

    modport shade (
        input board_hit, on_grid, cell_x, cell_y,
        input digit_hit, digit_sel, seg_sel
    );

endinterface

// ==== rtl/screen_locate.sv ====
module screen_locate import screen_pkg::*; #(
    parameter int BOARD_X0 = 203,
    parameter int BOARD_Y0 = 11
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic [PIX_W-1:0] x_i,
    input  logic [PIX_W-1:0] y_i,
    pix_loc_if.locate        loc
);

    localparam int BOARD_X1 = BOARD_X0 + BOARD_COLS * CELL_PITCH;   // right edge line
    localparam int BOARD_Y1 = BOARD_Y0 + BOARD_ROWS * CELL_PITCH;   // bottom edge line

    logic                board_d;
    logic                grid_d;
    logic [CELL_X_W-1:0] cx_d;
    logic [CELL_Y_W-1:0] cy_d;
    logic                digit_d;
    logic [DSEL_W-1:0]   dsel_d;
    logic [SEG_N-1:0]    seg_d;
    int                  off;
    int                  dx;     // x offset inside the glyph
    int                  band;

    ////////////////////////////////////////////////////////////
    // board cell and grid lines
    always_comb begin
        board_d = (x_i >= BOARD_X0) && (x_i <= BOARD_X1) && (y_i >= BOARD_Y0) && (y_i <= BOARD_Y1);
        grid_d  = 1'b0;
        cx_d    = '0;
        cy_d    = '0;
        for (int c = 0; c <= BOARD_COLS; c++) begin
            if (x_i == BOARD_X0 + c * CELL_PITCH) grid_d = 1'b1;
            if (c < BOARD_COLS && x_i >= BOARD_X0 + c * CELL_PITCH) cx_d = CELL_X_W'(c);
        end
        for (int r = 0; r <= BOARD_ROWS; r++) begin
            if (y_i == BOARD_Y0 + r * CELL_PITCH) grid_d = 1'b1;
            if (r < BOARD_ROWS && y_i >= BOARD_Y0 + r * CELL_PITCH) cy_d = CELL_Y_W'(r);
        end
    end

    ////////////////////////////////////////////////////////////
    // score glyph rectangle
    always_comb begin
        digit_d = 1'b0;
        dsel_d  = '0;
        dx      = 0;
        band    = 0;
        seg_d   = '0;
        for (int d = 0; d < DIGITS; d++) begin
            off = int'(x_i) - DIGIT_X0 - d * DIGIT_PITCH;
            if (off >= 0 && off <= COL_END[2]) begin
                digit_d = (y_i >= BAND_Y0) && (y_i <= BAND_END[BANDS-1]);
                dsel_d  = DSEL_W'(DIGITS - 1 - d);   // leftmost shows thousands
                dx      = off;
            end
        end
        for (int b = 0; b < BANDS - 1; b++)
            if (y_i > BAND_END[b]) band = b + 1;
        if (digit_d) begin
            if (dx <= COL_END[0])
                seg_d = SEG_N'(1) << band;                         // left column
            else if (dx > COL_END[1])
                seg_d = SEG_N'(1) << (BANDS + band);               // right column
            else if (band % 2 == 0)
                seg_d = SEG_N'(1) << (2 * BANDS + band / 2);       // mid, bands 0 2 4
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            loc.board_hit <= 1'b0;
            loc.on_grid   <= 1'b0;
            loc.cell_x    <= '0;
            loc.cell_y    <= '0;
            loc.digit_hit <= 1'b0;
            loc.digit_sel <= '0;
            loc.seg_sel   <= '0;
        end else begin
            loc.board_hit <= board_d;
            loc.on_grid   <= grid_d;
            loc.cell_x    <= cx_d;
            loc.cell_y    <= cy_d;
            loc.digit_hit <= digit_d;
            loc.digit_sel <= dsel_d;
            loc.seg_sel   <= seg_d;
        end
    end

endmodule

// ==== rtl/screen_pkg.sv ====
package screen_pkg;

    ////////////////////////////////////////////////////////////
    // widths and board geometry
    localparam int PIX_W       = 10;
    localparam int COLOUR_W    = 12;
    localparam int CELL_X_W    = 4;    // column index
    localparam int CELL_Y_W    = 5;    // row index
    localparam int BOARD_COLS  = 10;
    localparam int BOARD_ROWS  = 20;
    localparam int CELL_PITCH  = 23;   // 22 px cell + 1 px line
    localparam int PIECE_CELLS = 4;
    localparam int BTYPE_W     = 3;
    localparam int SCORE_W     = 14;   // holds 0..9999
    localparam int DIGITS      = 4;
    localparam int DSEL_W      = $clog2(DIGITS);
    localparam int BCD_W       = 4;
    localparam int SEG_N       = 13;
    localparam int BANDS       = 5;

    // score glyph placement, 3 columns x 5 bands per digit
    localparam int DIGIT_X0         = 50;
    localparam int DIGIT_PITCH      = 25;
    localparam int COL_END [3]      = '{4, 14, 19};   // last x offset per column
    localparam int BAND_Y0          = 139;
    localparam int BAND_END [BANDS] = '{143, 153, 158, 168, 173};

    ////////////////////////////////////////////////////////////
    // colours
    localparam logic [COLOUR_W-1:0] COL_BACKGROUND = 12'h000;
    localparam logic [COLOUR_W-1:0] COL_WHITE      = 12'hfff;
    localparam logic [COLOUR_W-1:0] COL_BORDER     = 12'h111;

    localparam logic [COLOUR_W-1:0] BLOCK_COLOUR [8] = '{
        12'h000, 12'hf00, 12'h0ff, 12'hf0f, 12'h0f8, 12'h08f, 12'h00f, 12'hdd4
    };

    // glyph bits {mid b4, mid b2, mid b0, right b4..b0, left b4..b0}
    // mid column has no segment in bands 1 and 3
    localparam logic [SEG_N-1:0] SEG_FONT [10] = '{
        13'b101_11111_11111, 13'b000_11111_00000, 13'b111_10111_11101,
        13'b111_11111_10101, 13'b010_11111_00111, 13'b111_11101_10111,
        13'b111_11101_11111, 13'b001_11111_00001, 13'b111_11111_11111,
        13'b111_11111_10111
    };

    ////////////////////////////////////////////////////////////
    // AXI4-Lite register map
    localparam int AXI_ADDR_W = 8;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    localparam logic [AXI_ADDR_W-1:0] REG_PIECE_X    = 8'h00;   // 4 x 4 bit columns
    localparam logic [AXI_ADDR_W-1:0] REG_PIECE_Y    = 8'h04;   // 4 x 5 bit rows
    localparam logic [AXI_ADDR_W-1:0] REG_BLOCK_TYPE = 8'h08;
    localparam logic [AXI_ADDR_W-1:0] REG_SCORE      = 8'h0c;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== rtl/screen_regs.sv ====
module screen_regs import screen_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [AXI_ADDR_W-1:0] s_awaddr_i,
    input  logic                  s_awvalid_i,
    output logic                  s_awready_o,
    input  logic [AXI_DATA_W-1:0] s_wdata_i,
    input  logic [AXI_STRB_W-1:0] s_wstrb_i,
    input  logic                  s_wvalid_i,
    output logic                  s_wready_o,
    output logic [1:0]            s_bresp_o,
    output logic                  s_bvalid_o,
    input  logic                  s_bready_i,
    input  logic [AXI_ADDR_W-1:0] s_araddr_i,
    input  logic                  s_arvalid_i,
    output logic                  s_arready_o,
    output logic [AXI_DATA_W-1:0] s_rdata_o,
    output logic [1:0]            s_rresp_o,
    output logic                  s_rvalid_o,
    input  logic                  s_rready_i,
    output logic [SCORE_W-1:0]    score_o,
    output logic                  score_load_o,
    piece_state_if.regs           pst
);

    localparam int PX_W = PIECE_CELLS * CELL_X_W;
    localparam int PY_W = PIECE_CELLS * CELL_Y_W;

    logic                                 wr_acc_q;    // awready and wready together
    logic                                 wr_fire;
    logic                                 rd_fire;
    logic [AXI_ADDR_W-1:0]                wr_word;
    logic [AXI_ADDR_W-1:0]                rd_word;
    logic [PIECE_CELLS-1:0][CELL_X_W-1:0] piece_x_q;
    logic [PIECE_CELLS-1:0][CELL_Y_W-1:0] piece_y_q;
    logic [BTYPE_W-1:0]                   btype_q;
    logic [SCORE_W-1:0]                   score_q;

    // byte lane merge under wstrb
    function automatic logic [AXI_DATA_W-1:0] merge(input logic [AXI_DATA_W-1:0] cur,
                                                    input logic [AXI_DATA_W-1:0] wdata,
                                                    input logic [AXI_STRB_W-1:0] strb);
        logic [AXI_DATA_W-1:0] res;
        res = cur;
        for (int b = 0; b < AXI_STRB_W; b++)
            if (strb[b]) res[8*b +: 8] = wdata[8*b +: 8];
        return res;
    endfunction

    assign s_awready_o = wr_acc_q;
    assign s_wready_o  = wr_acc_q;
    assign wr_fire     = wr_acc_q && s_awvalid_i && s_wvalid_i;
    assign rd_fire     = s_arready_o && s_arvalid_i;
    assign wr_word     = {s_awaddr_i[AXI_ADDR_W-1:2], 2'b00};   // byte offset dropped
    assign rd_word     = {s_araddr_i[AXI_ADDR_W-1:2], 2'b00};

    ////////////////////////////////////////////////////////////
    // write channel, one outstanding write
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_acc_q     <= 1'b0;
            s_bvalid_o   <= 1'b0;
            s_bresp_o    <= RESP_OKAY;
            score_load_o <= 1'b0;
            piece_x_q    <= '0;
            piece_y_q    <= '0;
            btype_q      <= '0;
            score_q      <= '0;
        end else begin
            // accept only with address and data both present and no pending response
            wr_acc_q     <= s_awvalid_i && s_wvalid_i && !wr_acc_q && !s_bvalid_o;
            score_load_o <= 1'b0;
            if (wr_fire) begin
                s_bvalid_o <= 1'b1;
                s_bresp_o  <= RESP_OKAY;
                case (wr_word)
                    REG_PIECE_X:    piece_x_q <= PX_W'(merge(AXI_DATA_W'(piece_x_q),
                                                             s_wdata_i, s_wstrb_i));
                    REG_PIECE_Y:    piece_y_q <= PY_W'(merge(AXI_DATA_W'(piece_y_q),
                                                             s_wdata_i, s_wstrb_i));
                    REG_BLOCK_TYPE: btype_q <= BTYPE_W'(merge(AXI_DATA_W'(btype_q),
                                                              s_wdata_i, s_wstrb_i));
                    REG_SCORE: begin
                        score_q      <= SCORE_W'(merge(AXI_DATA_W'(score_q),
                                                       s_wdata_i, s_wstrb_i));
                        score_load_o <= 1'b1;   // kicks the bcd converter
                    end
                    default:        s_bresp_o <= RESP_SLVERR;
                endcase
            end else if (s_bready_i) begin
                s_bvalid_o <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read channel
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s_arready_o <= 1'b0;
            s_rvalid_o  <= 1'b0;
            s_rdata_o   <= '0;
            s_rresp_o   <= RESP_OKAY;
        end else begin
            s_arready_o <= s_arvalid_i && !s_arready_o && !s_rvalid_o;   // one cycle pulse
            if (rd_fire) begin
                s_rvalid_o <= 1'b1;
                s_rresp_o  <= RESP_OKAY;
                case (rd_word)
                    REG_PIECE_X:    s_rdata_o <= AXI_DATA_W'(piece_x_q);
                    REG_PIECE_Y:    s_rdata_o <= AXI_DATA_W'(piece_y_q);
                    REG_BLOCK_TYPE: s_rdata_o <= AXI_DATA_W'(btype_q);
                    REG_SCORE:      s_rdata_o <= AXI_DATA_W'(score_q);
                    default: begin
                        s_rdata_o <= '0;
                        s_rresp_o <= RESP_SLVERR;
                    end
                endcase
            end else if (s_rready_i) begin
                s_rvalid_o <= 1'b0;
            end
        end
    end

    assign pst.piece_x    = piece_x_q;
    assign pst.piece_y    = piece_y_q;
    assign pst.block_type = btype_q;
    assign score_o        = score_q;

    // a stalled response keeps its value
    a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o))
        else $error("bvalid dropped before bready");

endmodule

// ==== rtl/screen_shade.sv ====
module screen_shade import screen_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,
    pix_loc_if.shade            loc,
    piece_state_if.shade        pst,
    output logic [COLOUR_W-1:0] colour_o
);

    logic                piece_hit;
    logic [BCD_W-1:0]    digit;
    logic [SEG_N-1:0]    font;
    logic                seg_lit;
    logic [COLOUR_W-1:0] colour_d;

    // any of the four piece cells under this board cell
    always_comb begin
        piece_hit = 1'b0;
        for (int i = 0; i < PIECE_CELLS; i++)
            if (pst.piece_x[i] == loc.cell_x && pst.piece_y[i] == loc.cell_y)
                piece_hit = 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // segment lighting
    assign digit   = pst.digits[loc.digit_sel];
    assign font    = (digit <= 4'd9) ? SEG_FONT[digit] : '0;   // blank on non bcd
    assign seg_lit = |(font & loc.seg_sel);

    // colour priority
    always_comb begin
        if (loc.digit_hit)
            colour_d = seg_lit ? COL_WHITE : COL_BACKGROUND;
        else if (loc.board_hit && loc.on_grid)
            colour_d = COL_BORDER;                         // grid wins over piece
        else if (loc.board_hit && piece_hit)
            colour_d = BLOCK_COLOUR[pst.block_type];
        else
            colour_d = COL_BACKGROUND;   // empty cells are black too
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i)
            colour_o <= '0;
        else
            colour_o <= colour_d;
    end

    // whole pipeline plus register state resolves to known colour
    a_colour_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(colour_o))
        else $error("colour_o unknown");

endmodule

// ==== tests/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

////////////////////////////////////////////////////////////
// compare tasks per result type
task automatic check_colour(input string what, input logic [COLOUR_W-1:0] got,
                            input logic [COLOUR_W-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error at %0t: %s = %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_data(input string what, input logic [AXI_DATA_W-1:0] got,
                          input logic [AXI_DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error at %0t: %s = %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_resp(input string what, input logic [1:0] got, input logic [1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error at %0t: %s = %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error at %0t: %s = %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic report_test(input string name, input int start);
    $display("[%0t] %s finished, %0d errors", $time, name, errors - start);
endtask

////////////////////////////////////////////////////////////
// AXI4-Lite master side entered and left on a falling edge
task automatic write_reg(input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_DATA_W-1:0] data,
                         input logic [AXI_STRB_W-1:0] strb, input int stall,
                         output logic [1:0] resp);
    @(negedge clk);
    s_awaddr  = addr;
    s_wdata   = data;
    s_wstrb   = strb;
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    @(negedge clk);
    while (!s_awready) @(negedge clk);   // handshake on the next rise
    check_flag("s_wready_o", s_wready, 1'b1);   // pulses with awready
    @(negedge clk);
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    while (!s_bvalid) @(negedge clk);
    repeat (stall) begin                 // response held back
        @(negedge clk);
        if (!s_bvalid) begin
            errors++;
            $display("bvalid fell at %0t while bready was still low", $time);
        end
    end
    resp    = s_bresp;
    s_bready = 1'b1;
    @(negedge clk);
    s_bready = 1'b0;
endtask

task automatic read_reg(input logic [AXI_ADDR_W-1:0] addr, output logic [AXI_DATA_W-1:0] data,
                        output logic [1:0] resp);
    @(negedge clk);
    s_araddr  = addr;
    s_arvalid = 1'b1;
    @(negedge clk);
    while (!s_arready) @(negedge clk);
    @(negedge clk);
    s_arvalid = 1'b0;
    while (!s_rvalid) @(negedge clk);
    data     = s_rdata;
    resp     = s_rresp;
    s_rready = 1'b1;
    @(negedge clk);
    s_rready = 1'b0;
endtask

task automatic write_read_back(input logic [AXI_ADDR_W-1:0] addr,
                               input logic [AXI_DATA_W-1:0] wdata,
                               input logic [AXI_STRB_W-1:0] strb,
                               input logic [AXI_DATA_W-1:0] exp);
    logic [AXI_DATA_W-1:0] data;
    logic [1:0]            resp;
    write_reg(addr, wdata, strb, 0, resp);
    check_resp($sformatf("s_bresp_o @%h", addr), resp, R_OKAY);
    read_reg(addr, data, resp);
    check_data($sformatf("s_rdata_o @%h", addr), data, exp);
    check_resp($sformatf("s_rresp_o @%h", addr), resp, R_OKAY);
endtask

// pixel colour two rising edges after it is driven
task automatic pixel_colour(input int px, input int py, input logic [COLOUR_W-1:0] exp);
    x = PIX_W'(px);
    y = PIX_W'(py);
    repeat (2) @(negedge clk);
    check_colour($sformatf("colour_o at (%0d,%0d)", px, py), colour, exp);
endtask

function automatic int cell_centre_x(input int c);
    return BX0 + PITCH * c + 12;
endfunction

function automatic int cell_centre_y(input int r);
    return BY0 + PITCH * r + 12;
endfunction

////////////////////////////////////////////////////////////
// directed tests
task automatic register_access();
    int                    start;
    logic [AXI_DATA_W-1:0] data;
    logic [1:0]            resp;
    start = errors;
    write_read_back(A_PIECE_X, 32'hdead_beef, 4'hf, 32'h0000_beef);   // 16 bit field
    write_read_back(A_PIECE_X, 32'h0000_0012, 4'h1, 32'h0000_be12);   // low lane only
    write_read_back(A_PIECE_Y, 32'hffff_ffff, 4'hf, 32'h000f_ffff);   // 20 bits
    write_read_back(A_BLOCK_TYPE, 32'h0000_00fd, 4'hf, 32'h0000_0005);
    write_read_back(A_SCORE, 32'd1234, 4'hf, 32'd1234);
    // unmapped offset
    write_reg(A_UNMAPPED, 32'h1234_5678, 4'hf, 0, resp);
    check_resp("s_bresp_o @10", resp, R_SLVERR);
    read_reg(A_UNMAPPED, data, resp);
    check_data("s_rdata_o @10", data, '0);
    check_resp("s_rresp_o @10", resp, R_SLVERR);
    // back pressure on b
    write_reg(A_BLOCK_TYPE, 32'h2, 4'hf, 5, resp);
    check_resp("s_bresp_o stalled", resp, R_OKAY);
    if (s_bvalid) begin
        errors++;
        $display("bvalid still high at %0t after bready was given", $time);
    end
    report_test("register access", start);
endtask

task automatic grid_and_background();
    int start;
    start = errors;
    pixel_colour(10, 10, C_BLACK);            // far outside
    pixel_colour(700, 300, C_BLACK);
    pixel_colour(BX0 - 1, 100, C_BLACK);      // just left of the board
    pixel_colour(BX0 + 10 * PITCH + 1, 100, C_BLACK);
    pixel_colour(300, BY0 + 20 * PITCH + 1, C_BLACK);
    for (int k = 0; k <= 10; k++)             // vertical lines with both edges
        pixel_colour(BX0 + PITCH * k, 90, C_GRID);
    for (int k = 0; k <= 20; k++)
        pixel_colour(BX0 + PITCH * 2 + 10, BY0 + PITCH * k, C_GRID);
    pixel_colour(cell_centre_x(4), cell_centre_y(7), C_BLACK);
    pixel_colour(cell_centre_x(9), cell_centre_y(19), C_BLACK);
    report_test("grid and background", start);
endtask

`endif

// ==== tests/tb_game_screen.sv ====
module tb_game_screen import screen_pkg::*; ();

    // geometry and colours as the screen is specified
    localparam int BX0            = 203;
    localparam int BY0            = 11;
    localparam int PITCH          = 23;
    localparam int GLYPH_X0       = 50;
    localparam int GLYPH_PITCH    = 25;
    localparam int TIMEOUT_CYCLES = 4000;

    localparam logic [COLOUR_W-1:0] C_BLACK = 12'h000;
    localparam logic [COLOUR_W-1:0] C_WHITE = 12'hfff;
    localparam logic [COLOUR_W-1:0] C_GRID  = 12'h111;
    localparam logic [COLOUR_W-1:0] PIECE_COLOUR [8] = '{
        12'h000, 12'hf00, 12'h0ff, 12'hf0f, 12'h0f8, 12'h08f, 12'h00f, 12'hdd4
    };

    localparam logic [AXI_ADDR_W-1:0] A_PIECE_X    = 8'h00;
    localparam logic [AXI_ADDR_W-1:0] A_PIECE_Y    = 8'h04;
    localparam logic [AXI_ADDR_W-1:0] A_BLOCK_TYPE = 8'h08;
    localparam logic [AXI_ADDR_W-1:0] A_SCORE      = 8'h0c;
    localparam logic [AXI_ADDR_W-1:0] A_UNMAPPED   = 8'h10;
    localparam logic [1:0]            R_OKAY       = 2'b00;
    localparam logic [1:0]            R_SLVERR     = 2'b10;

    logic                  clk;
    logic                  rst_n;
    logic [PIX_W-1:0]      x;
    logic [PIX_W-1:0]      y;
    logic [AXI_ADDR_W-1:0] s_awaddr;
    logic                  s_awvalid;
    logic                  s_awready;
    logic [AXI_DATA_W-1:0] s_wdata;
    logic [AXI_STRB_W-1:0] s_wstrb;
    logic                  s_wvalid;
    logic                  s_wready;
    logic [1:0]            s_bresp;
    logic                  s_bvalid;
    logic                  s_bready;
    logic [AXI_ADDR_W-1:0] s_araddr;
    logic                  s_arvalid;
    logic                  s_arready;
    logic [AXI_DATA_W-1:0] s_rdata;
    logic [1:0]            s_rresp;
    logic                  s_rvalid;
    logic                  s_rready;
    logic [COLOUR_W-1:0]   colour;
    int                    checks = 0;
    int                    errors = 0;
    int                    cycles = 0;
    int                    piece_col;    // cell 0 of the last piece
    int                    piece_row;

    `include "tb_tasks.svh"

    ////////////////////////////////////////////////////////////
    // tests that need the piece state
    task automatic piece_overlay();
        int                    start;
        int                    col [4];
        int                    row [4];
        int                    nc;
        bit                    taken;
        logic [AXI_DATA_W-1:0] px;
        logic [AXI_DATA_W-1:0] py;
        logic [1:0]            resp;
        start = errors;
        for (int t = 1; t < 8; t++) begin
            px = '0;
            py = '0;
            for (int i = 0; i < 4; i++) begin
                col[i] = $urandom_range(9);
                row[i] = $urandom_range(19);
                px |= AXI_DATA_W'(col[i]) << (4 * i);   // nibble per cell
                py |= AXI_DATA_W'(row[i]) << (5 * i);
            end
            write_reg(A_PIECE_X, px, 4'hf, 0, resp);
            write_reg(A_PIECE_Y, py, 4'hf, 0, resp);
            write_reg(A_BLOCK_TYPE, AXI_DATA_W'(t), 4'hf, 0, resp);
            for (int i = 0; i < 4; i++)
                pixel_colour(cell_centre_x(col[i]), cell_centre_y(row[i]), PIECE_COLOUR[t]);
            // next free column in the row of cell 0
            nc = col[0];
            do begin
                nc    = (nc + 1) % 10;
                taken = 1'b0;
                for (int i = 0; i < 4; i++)
                    if (col[i] == nc && row[i] == row[0]) taken = 1'b1;
            end while (taken);
            pixel_colour(cell_centre_x(nc), cell_centre_y(row[0]), C_BLACK);
        end
        piece_col = col[0];
        piece_row = row[0];
        report_test("piece overlay", start);
    endtask

    // border and piece pixels back to back, two in flight
    task automatic pixel_pipelining();
        int                  start;
        logic [COLOUR_W-1:0] exp_q [$];
        start = errors;
        for (int i = 0; i < 12; i++) begin
            if (i % 2 == 0) begin
                x = PIX_W'(BX0);                      // left edge line
                y = PIX_W'(BY0 + PITCH * i + 5);
                exp_q.push_back(C_GRID);
            end else begin
                x = PIX_W'(cell_centre_x(piece_col));
                y = PIX_W'(cell_centre_y(piece_row));
                exp_q.push_back(PIECE_COLOUR[7]);
            end
            @(negedge clk);
            if (i > 0) check_colour("colour_o in stream", colour, exp_q.pop_front());
        end
        @(negedge clk);
        check_colour("colour_o in stream", colour, exp_q.pop_front());
        report_test("pixel pipelining", start);
    endtask

    task automatic score_digits(input int value);
        int                  start;
        int                  dig;
        int                  gx;
        logic [COLOUR_W-1:0] mid_exp;
        logic [COLOUR_W-1:0] top_exp;
        logic [1:0]          resp;
        start = errors;
        write_reg(A_SCORE, AXI_DATA_W'(value), 4'hf, 0, resp);
        repeat (20) @(negedge clk);                   // conversion settles
        for (int p = 0; p < 4; p++) begin
            dig     = (value / (10 ** (3 - p))) % 10;   // leftmost is thousands
            gx      = GLYPH_X0 + GLYPH_PITCH * p;
            mid_exp = (dig inside {2, 3, 4, 5, 6, 8, 9}) ? C_WHITE : C_BLACK;
            top_exp = (dig inside {1, 4}) ? C_BLACK : C_WHITE;
            pixel_colour(gx + 10, 156, mid_exp);      // middle band centre
            pixel_colour(gx + 10, 141, top_exp);      // top band centre
            pixel_colour(gx + 22, 156, C_BLACK);      // gap after glyph
        end
        report_test($sformatf("score digits %0d", value), start);
    endtask

    game_screen #(.BOARD_X0(BX0), .BOARD_Y0(BY0)) u_game_screen (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .x_i         (x),
        .y_i         (y),
        .s_awaddr_i  (s_awaddr),
        .s_awvalid_i (s_awvalid),
        .s_awready_o (s_awready),
        .s_wdata_i   (s_wdata),
        .s_wstrb_i   (s_wstrb),
        .s_wvalid_i  (s_wvalid),
        .s_wready_o  (s_wready),
        .s_bresp_o   (s_bresp),
        .s_bvalid_o  (s_bvalid),
        .s_bready_i  (s_bready),
        .s_araddr_i  (s_araddr),
        .s_arvalid_i (s_arvalid),
        .s_arready_o (s_arready),
        .s_rdata_o   (s_rdata),
        .s_rresp_o   (s_rresp),
        .s_rvalid_o  (s_rvalid),
        .s_rready_i  (s_rready),
        .colour_o    (colour)
    );

    always #50 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a test stopped making progress", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h84aec321));
        clk       = 1'b0;
        rst_n     = 1'b0;
        x         = '0;
        y         = '0;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        grid_and_background();                        // registers still zero
        register_access();
        piece_overlay();
        pixel_pipelining();
        score_digits(2468);
        score_digits(1357);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+tests
rtl/screen_pkg.sv
rtl/screen_if.sv
rtl/screen_regs.sv
rtl/score_bcd.sv
rtl/screen_locate.sv
rtl/screen_shade.sv
rtl/game_screen.sv
tests/tb_game_screen.sv
